//--- verilog.f
+incdir+.
l2_cache_pkg.sv
l2_req_arbiter.sv
l2_way_bank.sv
l2_plru.sv
l2_ctrl_fsm.sv
l2_cache_top.sv
tb_l2_mem_model.sv
tb_l2_cache.sv

//--- run.sh
#!/bin/sh
# Build and run the L2 cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
    --top-module tb_l2_cache -f verilog.f -o tb_l2_cache

out=$(./obj_dir/tb_l2_cache)
echo "$out"

echo "$out" | grep -q "^RESULT: PASS$"

//--- tb_l2_cache.sv
`timescale 1ns/1ns
`default_nettype none

module tb_l2_cache;

    localparam int max_cycles = 200;

    logic         clk;
    logic         reset;
    logic         icache_req;
    logic [31:0]  icache_addr;
    logic         icache_addr_ok;
    logic         icache_data_ok;
    logic [127:0] icache_rdata;
    logic         dcache_req;
    logic         dcache_wr;
    logic [31:0]  dcache_addr;
    logic [31:0]  dcache_wdata;
    logic [3:0]   dcache_wstrb;
    logic         dcache_addr_ok;
    logic         dcache_data_ok;
    logic [127:0] dcache_rdata;
    logic         mem_req_r;
    logic [31:0]  mem_addr_r;
    logic         mem_addr_ok_r;
    logic         mem_data_ok;
    logic [127:0] mem_rdata;
    logic         mem_req_w;
    logic [31:0]  mem_addr_w;
    logic [127:0] mem_wdata;
    logic         mem_addr_ok_w;

    // Expected memory contents and lines dirtied in the cache
    logic [127:0] shadow [logic [31:0]];
    bit           dirty_lines [logic [31:0]];
    logic [127:0] i_line;
    logic [127:0] d_line;
    logic [31:0]  last_raddr;
    // Line of the request last accepted
    logic [31:0]  req_line;
    logic [31:0]  wb_line;
    logic         refetched;
    int i_acc;
    int d_acc;
    int i_lat;
    int d_lat;
    int errors;
    int start_errors;
    int tests_passed;
    int tests_failed;
    int read_count;
    int wb_count;
    int reads_before;

    l2_cache_top uut (.*);

    tb_l2_mem_model u_mem (.*);

    always #10 clk = ~clk;

    function automatic logic [127:0] expected_line(input logic [31:0] addr);
        logic [31:0]  la;
        logic [127:0] l;
        la = {addr[31:4], 4'h0};
        if (shadow.exists(la)) begin
            return shadow[la];
        end
        for (int w = 0; w < 4; w++) begin
            l[w * 32 +: 32] = (la + 32'(4 * w)) ^ 32'h5a5a0000;
        end
        return l;
    endfunction

    task automatic report_value(input string name, input logic [127:0] got,
                                input logic [127:0] exp);
        $display("FAIL %s got %h expected %h", name, got, exp);
        errors++;
    endtask

    task automatic report_text(input string msg);
        $display("ERROR %s", msg);
        errors++;
    endtask

    task automatic end_test(input string name);
        if (errors == start_errors) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - start_errors);
        end
        start_errors = errors;
    endtask

    // Runs from a falling edge until every raised request has its data_ok
    task automatic access(input logic use_i, input logic use_d, input logic [31:0] i_addr,
                          input logic d_wr, input logic [31:0] d_addr,
                          input logic [31:0] d_wdata, input logic [3:0] d_strb);
        logic i_busy;
        logic d_busy;
        logic i_seen;
        logic d_seen;
        int   cyc;
        i_busy = use_i;
        d_busy = use_d;
        cyc = 0;
        icache_req = use_i;
        icache_addr = i_addr;
        dcache_req = use_d;
        dcache_wr = d_wr;
        dcache_addr = d_addr;
        dcache_wdata = d_wdata;
        dcache_wstrb = d_strb;
        while ((i_busy || d_busy) && cyc < max_cycles) begin
            #5;
            i_seen = icache_addr_ok;
            d_seen = dcache_addr_ok;
            assert (!(i_seen && d_seen)) else report_text("both addr_ok strobes high together");
            assert (!(icache_data_ok && !i_busy) && !(dcache_data_ok && !d_busy))
                else report_text("data_ok without an outstanding request");
            if (i_seen) begin
                i_acc = cyc;
                req_line = {i_addr[31:4], 4'h0};
            end
            if (d_seen) begin
                d_acc = cyc;
                req_line = {d_addr[31:4], 4'h0};
            end
            if (icache_data_ok) begin
                i_line = icache_rdata;
                i_lat = cyc - i_acc;
                i_busy = 1'b0;
            end
            if (dcache_data_ok) begin
                d_line = dcache_rdata;
                d_lat = cyc - d_acc;
                d_busy = 1'b0;
            end
            @(negedge clk);
            if (i_seen) begin
                icache_req = 1'b0;
            end
            if (d_seen) begin
                dcache_req = 1'b0;
            end
            cyc++;
        end
        assert (!i_busy && !d_busy) else report_text("timeout waiting for data_ok");
    endtask

    task automatic read_check(input logic [31:0] addr);
        logic [127:0] exp;
        exp = expected_line(addr);
        access(1'b0, 1'b1, '0, 1'b0, addr, '0, '0);
        assert (d_line == exp) else report_value("dcache_rdata", d_line, exp);
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        logic [127:0] old;
        logic [127:0] upd;
        old = expected_line(addr);
        upd = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                upd[32'(addr[3:2]) * 32 + b * 8 +: 8] = data[b * 8 +: 8];
            end
        end
        access(1'b0, 1'b1, '0, 1'b1, addr, data, strb);
        // data_ok carries the line as it was before the merge
        assert (d_line == old) else report_value("dcache_rdata", d_line, old);
        shadow[{addr[31:4], 4'h0}] = upd;
        dirty_lines[{addr[31:4], 4'h0}] = 1'b1;
    endtask

    // Memory side watcher, sampled mid low phase
    always @(negedge clk) begin
        #5;
        if (mem_req_r) begin
            assert (mem_addr_r == req_line)
                else report_value("mem_addr_r", 128'(mem_addr_r), 128'(req_line));
            last_raddr = mem_addr_r;
        end
        if (mem_req_r && mem_addr_ok_r) begin
            read_count++;
            if (mem_addr_r == wb_line) begin
                refetched = 1'b1;
            end
        end
        if (mem_req_w && mem_addr_ok_w) begin
            wb_count++;
            assert (dirty_lines.exists(mem_addr_w)) else report_text("write-back of a clean line");
            assert (mem_wdata == expected_line(mem_addr_w))
                else report_value("mem_wdata", mem_wdata, expected_line(mem_addr_w));
            dirty_lines.delete(mem_addr_w);
            wb_line = mem_addr_w;
            refetched = 1'b0;
        end
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        icache_req = 1'b0;
        icache_addr = '0;
        dcache_req = 1'b0;
        dcache_wr = 1'b0;
        dcache_addr = '0;
        dcache_wdata = '0;
        dcache_wstrb = '0;
        last_raddr = '1;
        req_line = '1;
        wb_line = '1;
        refetched = 1'b0;
        errors = 0;
        start_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        read_count = 0;
        wb_count = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        #5;
        assert (!(icache_addr_ok || icache_data_ok || dcache_addr_ok || dcache_data_ok
                  || mem_req_r || mem_req_w)) else report_text("strobe high after reset");
        @(negedge clk);
        read_check(32'h0000_0024);
        assert (last_raddr == 32'h0000_0020)
            else report_value("mem_addr_r", 128'(last_raddr), 128'h20);
        end_test("reset and first read");

        access(1'b1, 1'b0, 32'h0000_0134, 1'b0, '0, '0, '0);
        assert (i_line == expected_line(32'h0000_0134))
            else report_value("icache_rdata", i_line, expected_line(32'h0000_0134));
        reads_before = read_count;
        access(1'b1, 1'b0, 32'h0000_0134, 1'b0, '0, '0, '0);
        assert (read_count == reads_before) else report_text("read hit went to memory");
        assert (i_lat == 1) else report_value("icache_data_ok latency", 128'(i_lat), 128'd1);
        assert (i_line == expected_line(32'h0000_0134))
            else report_value("icache_rdata", i_line, expected_line(32'h0000_0134));
        end_test("read miss then hit");

        access(1'b1, 1'b1, 32'h0000_0208, 1'b0, 32'h0000_0328, '0, '0);
        assert (d_acc < i_acc) else report_text("instruction side accepted before data side");
        assert (i_line == expected_line(32'h0000_0208))
            else report_value("icache_rdata", i_line, expected_line(32'h0000_0208));
        assert (d_line == expected_line(32'h0000_0328))
            else report_value("dcache_rdata", d_line, expected_line(32'h0000_0328));
        end_test("arbitration");

        write_word(32'h0000_0024, 32'hdead_beef, 4'b0101);
        assert (d_lat == 1) else report_value("dcache_data_ok latency", 128'(d_lat), 128'd1);
        write_word(32'h0000_002c, 32'h1122_3344, 4'b1000);
        read_check(32'h0000_0020);
        end_test("write hit merge");

        // Five tags share set 1
        for (int k = 0; k < 4; k++) begin
            read_check(32'h0001_0010 + 32'(k) * 32'h100);
        end
        write_word(32'h0001_0014, 32'ha5a5_a5a5, 4'b1111);
        write_word(32'h0001_0218, 32'h0000_c3c3, 4'b0011);
        for (int k = 4; k < 14; k++) begin
            read_check(32'h0001_0010 + 32'(k % 5) * 32'h100);
            if (k == 7) begin
                write_word(32'h0001_011c, 32'h7700_0000, 4'b1000);
            end
        end
        assert (wb_count > 0) else report_text("no write-back seen during evictions");
        end_test("dirty eviction");

        read_check(wb_line);
        assert (refetched) else report_text("evicted line was not fetched from memory");
        end_test("re-read after eviction");

        $display("tests passed %0d failed %0d errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_l2_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module tb_l2_mem_model (
    input  logic         clk,
    input  logic         reset,
    input  logic         mem_req_r,
    input  logic [31:0]  mem_addr_r,
    output logic         mem_addr_ok_r,
    output logic         mem_data_ok,
    output logic [127:0] mem_rdata,
    input  logic         mem_req_w,
    input  logic [31:0]  mem_addr_w,
    input  logic [127:0] mem_wdata,
    output logic         mem_addr_ok_w
);

    // Only lines written back are kept, the rest follow the fill pattern
    logic [127:0] lines [logic [31:0]];
    logic [31:0]  read_addr;
    logic         read_pending;
    int           seed;
    int           delay;

    function automatic logic [127:0] stored_line(input logic [31:0] addr);
        logic [127:0] l;
        if (lines.exists(addr)) begin
            return lines[addr];
        end
        for (int w = 0; w < 4; w++) begin
            l[w * 32 +: 32] = (addr + 32'(4 * w)) ^ 32'h5a5a0000;
        end
        return l;
    endfunction

    initial begin
        seed = 32'h8f6d3d08;
        mem_addr_ok_r = 1'b0;
        mem_addr_ok_w = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata = '0;
        read_addr = '0;
        read_pending = 1'b0;
        delay = 0;
        forever begin
            @(negedge clk);
            mem_addr_ok_r = 1'b0;
            mem_addr_ok_w = 1'b0;
            mem_data_ok = 1'b0;
            if (reset) begin
                read_pending = 1'b0;
            end else if (delay > 0) begin
                delay--;
            end else if (read_pending) begin
                mem_data_ok = 1'b1;
                mem_rdata = stored_line(read_addr);
                read_pending = 1'b0;
                delay = int'($unsigned($random(seed)) % 4);
            end else if (mem_req_w) begin
                mem_addr_ok_w = 1'b1;
                lines[mem_addr_w] = mem_wdata;
                delay = int'($unsigned($random(seed)) % 4);
            end else if (mem_req_r) begin
                mem_addr_ok_r = 1'b1;
                read_addr = mem_addr_r;
                read_pending = 1'b1;
                delay = int'($unsigned($random(seed)) % 4);
            end
        end
    end

endmodule

`default_nettype wire

//--- l2_cache_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "l2_cache_defs.svh"

module l2_cache_top (
    input  logic                      clk,
    input  logic                      reset,
    // Instruction L1
    input  logic                      icache_req,
    input  logic [31:0]               icache_addr,
    output logic                      icache_addr_ok,
    output logic                      icache_data_ok,
    output logic [`L2_LINE_BITS-1:0]  icache_rdata,
    // Data L1
    input  logic                      dcache_req,
    input  logic                      dcache_wr,
    input  logic [31:0]               dcache_addr,
    input  logic [31:0]               dcache_wdata,
    input  logic [3:0]                dcache_wstrb,
    output logic                      dcache_addr_ok,
    output logic                      dcache_data_ok,
    output logic [`L2_LINE_BITS-1:0]  dcache_rdata,
    // Memory bridge
    output logic                      mem_req_r,
    output logic [31:0]               mem_addr_r,
    input  logic                      mem_addr_ok_r,
    input  logic                      mem_data_ok,
    input  logic [`L2_LINE_BITS-1:0]  mem_rdata,
    output logic                      mem_req_w,
    output logic [31:0]               mem_addr_w,
    output logic [`L2_LINE_BITS-1:0]  mem_wdata,
    input  logic                      mem_addr_ok_w
);

    l2_cache_pkg::l2_source_t grant_source;
    l2_cache_pkg::l2_source_t buf_source;

    logic [`L2_INDEX_WIDTH-1:0]                 buf_index;
    logic [`L2_TAG_WIDTH-1:0]                   buf_tag;
    logic [`L2_OFFSET_WIDTH-1:0]                buf_offset;
    logic [31:0]                                buf_wdata;
    logic [3:0]                                 buf_wstrb;
    logic [31:0]                                buf_addr;
    logic                                       accept;
    logic [`L2_WAYS-1:0]                        write_en_vec;
    logic [`L2_WAYS-1:0]                        fill_en_vec;
    logic [`L2_WAYS-1:0]                        hit_vec;
    logic [`L2_WAYS-1:0]                        valid_vec;
    logic [`L2_WAYS-1:0]                        dirty_vec;
    logic [`L2_WAYS-1:0][`L2_TAG_WIDTH-1:0]     victim_tags;
    logic [`L2_WAYS-1:0][`L2_LINE_BITS-1:0]     way_lines;
    logic                                       touch;
    logic [`L2_WAY_BITS-1:0]                    touch_way;
    logic [`L2_WAY_BITS-1:0]                    plru_victim;
    logic [`L2_LINE_BITS-1:0]                   rdata;

    l2_req_arbiter u_arbiter (
        .clk          (clk),
        .reset        (reset),
        .icache_req   (icache_req),
        .icache_addr  (icache_addr),
        .dcache_req   (dcache_req),
        .dcache_wr    (dcache_wr),
        .dcache_addr  (dcache_addr),
        .dcache_wdata (dcache_wdata),
        .dcache_wstrb (dcache_wstrb),
        .accept       (accept),
        .grant_source (grant_source),
        .buf_source   (buf_source),
        .buf_index    (buf_index),
        .buf_tag      (buf_tag),
        .buf_offset   (buf_offset),
        .buf_wdata    (buf_wdata),
        .buf_wstrb    (buf_wstrb),
        .buf_addr     (buf_addr)
    );

    for (genvar g = 0; g < `L2_WAYS; g++) begin : g_way
        l2_way_bank u_bank (
            .clk        (clk),
            .reset      (reset),
            .index      (buf_index),
            .tag        (buf_tag),
            .offset     (buf_offset),
            .wdata      (buf_wdata),
            .wstrb      (buf_wstrb),
            .write_en   (write_en_vec[g]),
            .fill_en    (fill_en_vec[g]),
            .fill_line  (mem_rdata),
            .hit        (hit_vec[g]),
            .valid      (valid_vec[g]),
            .dirty      (dirty_vec[g]),
            .victim_tag (victim_tags[g]),
            .line       (way_lines[g])
        );
    end

    l2_plru u_plru (
        .clk        (clk),
        .reset      (reset),
        .index      (buf_index),
        .touch      (touch),
        .touch_way  (touch_way),
        .victim_way (plru_victim)
    );

    l2_ctrl_fsm u_ctrl (
        .clk            (clk),
        .reset          (reset),
        .grant_source   (grant_source),
        .buf_source     (buf_source),
        .buf_index      (buf_index),
        .buf_addr       (buf_addr),
        .hit_vec        (hit_vec),
        .valid_vec      (valid_vec),
        .dirty_vec      (dirty_vec),
        .victim_tags    (victim_tags),
        .way_lines      (way_lines),
        .plru_victim    (plru_victim),
        .mem_addr_ok_r  (mem_addr_ok_r),
        .mem_addr_ok_w  (mem_addr_ok_w),
        .mem_data_ok    (mem_data_ok),
        .accept         (accept),
        .write_en_vec   (write_en_vec),
        .fill_en_vec    (fill_en_vec),
        .touch          (touch),
        .touch_way      (touch_way),
        .icache_addr_ok (icache_addr_ok),
        .icache_data_ok (icache_data_ok),
        .dcache_addr_ok (dcache_addr_ok),
        .dcache_data_ok (dcache_data_ok),
        .rdata          (rdata),
        .mem_req_r      (mem_req_r),
        .mem_addr_r     (mem_addr_r),
        .mem_req_w      (mem_req_w),
        .mem_addr_w     (mem_addr_w),
        .mem_wdata      (mem_wdata)
    );

    // One line feeds both L1 read ports
    assign icache_rdata = rdata;
    assign dcache_rdata = rdata;

endmodule

`default_nettype wire

//--- l2_ctrl_fsm.sv
`timescale 1ns/1ns
`default_nettype none

`include "l2_cache_defs.svh"

module l2_ctrl_fsm (
    input  logic                                        clk,
    input  logic                                        reset,
    input  l2_cache_pkg::l2_source_t                    grant_source,
    input  l2_cache_pkg::l2_source_t                    buf_source,
    input  logic [`L2_INDEX_WIDTH-1:0]                  buf_index,
    input  logic [31:0]                                 buf_addr,
    input  logic [`L2_WAYS-1:0]                         hit_vec,
    input  logic [`L2_WAYS-1:0]                         valid_vec,
    input  logic [`L2_WAYS-1:0]                         dirty_vec,
    input  logic [`L2_WAYS-1:0][`L2_TAG_WIDTH-1:0]      victim_tags,
    input  logic [`L2_WAYS-1:0][`L2_LINE_BITS-1:0]      way_lines,
    input  logic [`L2_WAY_BITS-1:0]                     plru_victim,
    input  logic                                        mem_addr_ok_r,
    input  logic                                        mem_addr_ok_w,
    input  logic                                        mem_data_ok,
    output logic                                        accept,
    output logic [`L2_WAYS-1:0]                         write_en_vec,
    output logic [`L2_WAYS-1:0]                         fill_en_vec,
    output logic                                        touch,
    output logic [`L2_WAY_BITS-1:0]                     touch_way,
    output logic                                        icache_addr_ok,
    output logic                                        icache_data_ok,
    output logic                                        dcache_addr_ok,
    output logic                                        dcache_data_ok,
    output logic [`L2_LINE_BITS-1:0]                    rdata,
    output logic                                        mem_req_r,
    output logic [31:0]                                 mem_addr_r,
    output logic                                        mem_req_w,
    output logic [31:0]                                 mem_addr_w,
    output logic [`L2_LINE_BITS-1:0]                    mem_wdata
);

    l2_cache_pkg::l2_ctrl_state_t state;
    l2_cache_pkg::l2_ctrl_state_t state_next;

    logic                    hit_any;
    logic                    lookup_hit;
    logic [`L2_WAY_BITS-1:0] hit_way;
    logic [`L2_WAY_BITS-1:0] miss_way;
    logic [`L2_WAY_BITS-1:0] victim_way;

    assign hit_any    = |hit_vec;
    assign lookup_hit = (state == l2_cache_pkg::LOOKUP) && hit_any;

    // Hit vector is one-hot
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (hit_vec[w]) begin
                hit_way = w[`L2_WAY_BITS-1:0];
            end
        end
    end

    // Lowest invalid way first, tree choice otherwise
    always_comb begin
        miss_way = plru_victim;
        for (int w = `L2_WAYS - 1; w >= 0; w--) begin
            if (!valid_vec[w]) begin
                miss_way = w[`L2_WAY_BITS-1:0];
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            l2_cache_pkg::IDLE: begin
                if (accept) begin
                    state_next = l2_cache_pkg::LOOKUP;
                end
            end
            l2_cache_pkg::LOOKUP: begin
                if (hit_any) begin
                    state_next = l2_cache_pkg::IDLE;
                end else if (valid_vec[miss_way] && dirty_vec[miss_way]) begin
                    state_next = l2_cache_pkg::WB_REQ;
                end else begin
                    state_next = l2_cache_pkg::REFILL_REQ;
                end
            end
            l2_cache_pkg::WB_REQ: begin
                if (mem_addr_ok_w) begin
                    state_next = l2_cache_pkg::REFILL_REQ;
                end
            end
            l2_cache_pkg::REFILL_REQ: begin
                if (mem_addr_ok_r) begin
                    state_next = l2_cache_pkg::REFILL_WAIT;
                end
            end
            l2_cache_pkg::REFILL_WAIT: begin
                if (mem_data_ok) begin
                    state_next = l2_cache_pkg::LOOKUP;
                end
            end
            default: state_next = l2_cache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= l2_cache_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if ((state == l2_cache_pkg::LOOKUP) && !hit_any) begin
            victim_way <= miss_way;
        end
    end

    // L1 side strobes
    assign accept = (state == l2_cache_pkg::IDLE) && (grant_source != l2_cache_pkg::SRC_NONE);
    assign icache_addr_ok = accept && (grant_source == l2_cache_pkg::SRC_ICACHE);
    assign dcache_addr_ok = accept && (grant_source != l2_cache_pkg::SRC_ICACHE);
    assign icache_data_ok = lookup_hit && (buf_source == l2_cache_pkg::SRC_ICACHE);
    assign dcache_data_ok = lookup_hit && (buf_source != l2_cache_pkg::SRC_ICACHE);

    // Line before any store merge
    assign rdata = way_lines[hit_way];

    assign write_en_vec = (lookup_hit && (buf_source == l2_cache_pkg::SRC_DWRITE)) ?
                          hit_vec : '0;
    assign fill_en_vec  = ((state == l2_cache_pkg::REFILL_WAIT) && mem_data_ok) ?
                          ({{(`L2_WAYS-1){1'b0}}, 1'b1} << victim_way) : '0;
    assign touch     = lookup_hit;
    assign touch_way = hit_way;

    // Memory side
    assign mem_req_w  = (state == l2_cache_pkg::WB_REQ);
    assign mem_addr_w = {victim_tags[victim_way], buf_index, {`L2_INDEX_LSB{1'b0}}};
    assign mem_wdata  = way_lines[victim_way];
    assign mem_req_r  = (state == l2_cache_pkg::REFILL_REQ);
    assign mem_addr_r = {buf_addr[31:`L2_INDEX_LSB], {`L2_INDEX_LSB{1'b0}}};

endmodule

`default_nettype wire

//--- l2_plru.sv
`timescale 1ns/1ns
`default_nettype none

`include "l2_cache_defs.svh"

module l2_plru (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`L2_INDEX_WIDTH-1:0]  index,
    input  logic                        touch,
    input  logic [`L2_WAY_BITS-1:0]     touch_way,
    output logic [`L2_WAY_BITS-1:0]     victim_way
);

    // Bit 0 picks the half, bit 1 the low pair, bit 2 the high pair
    logic [`L2_SETS-1:0][`L2_WAYS-2:0] tree;
    logic [`L2_WAYS-2:0]               cur;

    assign cur = tree[index];

    always_comb begin
        if (cur[0]) begin
            victim_way = {1'b1, cur[2]};
        end else begin
            victim_way = {1'b0, cur[1]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tree <= '0;
        end else if (touch) begin
            // Point every level away from the touched way
            tree[index][0] <= ~touch_way[1];
            if (touch_way[1]) begin
                tree[index][2] <= ~touch_way[0];
            end else begin
                tree[index][1] <= ~touch_way[0];
            end
        end
    end

endmodule

`default_nettype wire

//--- l2_way_bank.sv
`timescale 1ns/1ns
`default_nettype none

`include "l2_cache_defs.svh"

module l2_way_bank (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`L2_INDEX_WIDTH-1:0]  index,
    input  logic [`L2_TAG_WIDTH-1:0]    tag,
    input  logic [`L2_OFFSET_WIDTH-1:0] offset,
    input  logic [31:0]                 wdata,
    input  logic [3:0]                  wstrb,
    input  logic                        write_en,
    input  logic                        fill_en,
    input  logic [`L2_LINE_BITS-1:0]    fill_line,
    output logic                        hit,
    output logic                        valid,
    output logic                        dirty,
    output logic [`L2_TAG_WIDTH-1:0]    victim_tag,
    output logic [`L2_LINE_BITS-1:0]    line
);

    logic [`L2_TAG_WIDTH-1:0]  tag_mem  [`L2_SETS];
    logic [`L2_LINE_BITS-1:0]  line_mem [`L2_SETS];
    logic [`L2_SETS-1:0]       valid_bits;
    logic [`L2_SETS-1:0]       dirty_bits;
    logic [`L2_LINE_BITS-1:0]  merged;

    // Read side, all at the buffered index
    assign valid      = valid_bits[index];
    assign dirty      = dirty_bits[index];
    assign victim_tag = tag_mem[index];
    assign line       = line_mem[index];
    assign hit        = valid && (tag_mem[index] == tag);

    // Byte merge of the store word into the stored line
    always_comb begin
        merged = line_mem[index];
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
                merged[offset * 32 + b * 8 +: 8] = wdata[b * 8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (fill_en) begin
            valid_bits[index] <= 1'b1;
            dirty_bits[index] <= 1'b0;
        end else if (write_en) begin
            dirty_bits[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[index]  <= tag;
            line_mem[index] <= fill_line;
        end else if (write_en) begin
            line_mem[index] <= merged;
        end
    end

endmodule

`default_nettype wire

//--- l2_req_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

`include "l2_cache_defs.svh"

module l2_req_arbiter (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               icache_req,
    input  logic [31:0]                        icache_addr,
    input  logic                               dcache_req,
    input  logic                               dcache_wr,
    input  logic [31:0]                        dcache_addr,
    input  logic [31:0]                        dcache_wdata,
    input  logic [3:0]                         dcache_wstrb,
    input  logic                               accept,
    output l2_cache_pkg::l2_source_t           grant_source,
    output l2_cache_pkg::l2_source_t           buf_source,
    output logic [`L2_INDEX_WIDTH-1:0]         buf_index,
    output logic [`L2_TAG_WIDTH-1:0]           buf_tag,
    output logic [`L2_OFFSET_WIDTH-1:0]        buf_offset,
    output logic [31:0]                        buf_wdata,
    output logic [3:0]                         buf_wstrb,
    output logic [31:0]                        buf_addr
);

    logic [31:0] sel_addr;

    // Data side wins
    always_comb begin
        if (dcache_req) begin
            grant_source = dcache_wr ? l2_cache_pkg::SRC_DWRITE : l2_cache_pkg::SRC_DREAD;
        end else if (icache_req) begin
            grant_source = l2_cache_pkg::SRC_ICACHE;
        end else begin
            grant_source = l2_cache_pkg::SRC_NONE;
        end
    end

    assign sel_addr = dcache_req ? dcache_addr : icache_addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            buf_source <= l2_cache_pkg::SRC_NONE;
        end else if (accept) begin
            buf_source <= grant_source;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_addr  <= sel_addr;
            buf_wdata <= dcache_wdata;
            // Instruction fetches never write
            buf_wstrb <= dcache_req ? dcache_wstrb : 4'b0000;
        end
    end

    assign buf_offset = buf_addr[`L2_INDEX_LSB-1:`L2_OFFSET_LSB];
    assign buf_index  = buf_addr[`L2_TAG_LSB-1:`L2_INDEX_LSB];
    assign buf_tag    = buf_addr[31:`L2_TAG_LSB];

endmodule

`default_nettype wire

//--- l2_cache_pkg.sv
`default_nettype none

package l2_cache_pkg;

    // Controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WB_REQ,
        REFILL_REQ,
        REFILL_WAIT
    } l2_ctrl_state_t;

    // Origin of a request, data read and write kept apart
    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_ICACHE,
        SRC_DREAD,
        SRC_DWRITE
    } l2_source_t;

endpackage

`default_nettype wire

//--- l2_cache_defs.svh
`ifndef L2_CACHE_DEFS_SVH
`define L2_CACHE_DEFS_SVH

// Geometry
`define L2_WAYS         4
`define L2_WAY_BITS     2
`define L2_INDEX_WIDTH  2
`define L2_SETS         (1 << `L2_INDEX_WIDTH)
`define L2_OFFSET_WIDTH 2
`define L2_LINE_BITS    128
`define L2_TAG_WIDTH    26

// Address field positions, byte bits at the bottom
`define L2_OFFSET_LSB   2
`define L2_INDEX_LSB    (`L2_OFFSET_LSB + `L2_OFFSET_WIDTH)
`define L2_TAG_LSB      (`L2_INDEX_LSB + `L2_INDEX_WIDTH)

`endif
